/* Makefile */
TOP := tb_serial_tx

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f project.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

/* project.f */
+incdir+verification
source/txbuf_pkg.sv
source/fifo_if.sv
source/sram_sp.sv
source/byte_fifo.sv
source/host_write_port.sv
source/frame_serializer.sv
source/serial_tx_top.sv
verification/tb_serial_tx.sv

/* source/byte_fifo.sv */
// byte FIFO control over one single-port memory
// write and read pointers, registered full and empty flags,
// level count, synchronous clear

module byte_fifo (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clr_i,
  fifo_if.buffer                        fif,
  output logic [txbuf_pkg::LEVEL_W-1:0] level_o
);
  import txbuf_pkg::*;

  logic [ADDR_W-1:0]  w_ptr_q;
  logic [ADDR_W-1:0]  w_ptr_d;
  logic [ADDR_W-1:0]  w_ptr_succ;
  logic [ADDR_W-1:0]  r_ptr_q;
  logic [ADDR_W-1:0]  r_ptr_d;
  logic [ADDR_W-1:0]  r_ptr_succ;
  logic [ADDR_W-1:0]  mem_addr;
  logic [LEVEL_W-1:0] level_q;
  logic [LEVEL_W-1:0] level_d;
  logic               full_q;
  logic               full_d;
  logic               empty_q;
  logic               empty_d;
  logic               do_push;
  logic               do_pop;
  logic               mem_en;

  ////////////////////////////////////////////////////////////
  // handshake and memory port
  ////////////////////////////////////////////////////////////

  // read wins the single port, so no push while popping
  assign fif.push_ready = ~full_q & ~fif.pop & ~clr_i;
  assign fif.empty      = empty_q;
  assign level_o        = level_q;

  assign do_push  = fif.push & fif.push_ready;
  assign do_pop   = fif.pop & ~empty_q;
  assign mem_en   = do_push | do_pop;
  assign mem_addr = do_pop ? r_ptr_q : w_ptr_q;

  ////////////////////////////////////////////////////////////
  // pointer and flag update
  ////////////////////////////////////////////////////////////

  always_comb begin
    w_ptr_succ = w_ptr_q + 1'b1;
    r_ptr_succ = r_ptr_q + 1'b1;
    w_ptr_d    = w_ptr_q;
    r_ptr_d    = r_ptr_q;
    full_d     = full_q;
    empty_d    = empty_q;
    level_d    = level_q;

    case ({do_push, do_pop})
      2'b01: begin
        // pop
        r_ptr_d = r_ptr_succ;
        full_d  = 1'b0;
        level_d = level_q - 1'b1;
        if (r_ptr_succ == w_ptr_q) begin
          empty_d = 1'b1;
        end
      end
      2'b10: begin
        // push
        w_ptr_d = w_ptr_succ;
        empty_d = 1'b0;
        level_d = level_q + 1'b1;
        if (w_ptr_succ == r_ptr_q) begin
          full_d = 1'b1;
        end
      end
      default: begin
        // state holds on an idle cycle
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_ptr_q <= '0;
      r_ptr_q <= '0;
      full_q  <= 1'b0;
      empty_q <= 1'b1;
      level_q <= '0;
    end else if (clr_i) begin
      w_ptr_q <= '0;
      r_ptr_q <= '0;
      full_q  <= 1'b0;
      empty_q <= 1'b1;
      level_q <= '0;
    end else begin
      w_ptr_q <= w_ptr_d;
      r_ptr_q <= r_ptr_d;
      full_q  <= full_d;
      empty_q <= empty_d;
      level_q <= level_d;
    end
  end

  // storage
  sram_sp i_sram (
    .clk_i   (clk_i),
    .en_i    (mem_en),
    .we_i    (do_push),
    .addr_i  (mem_addr),
    .wdata_i (fif.push_data),
    .rdata_o (fif.pop_data)
  );

endmodule

/* source/fifo_if.sv */
// push and pop sides of the byte FIFO
// modports for producer, buffer and consumer

interface fifo_if (
  input logic clk_i,
  input logic rst_ni
);
  import txbuf_pkg::*;

  // push side
  logic              push;
  logic [DATA_W-1:0] push_data;
  logic              push_ready;

  // pop side
  logic              pop;
  logic [DATA_W-1:0] pop_data;
  logic              empty;

  modport producer (
    output push,
    output push_data,
    input  push_ready
  );

  modport buffer (
    input  push,
    input  push_data,
    output push_ready,
    input  pop,
    output pop_data,
    output empty
  );

  modport consumer (
    output pop,
    input  pop_data,
    input  empty
  );

endinterface

/* source/frame_serializer.sv */
// frame serializer on the FIFO pop side
// eight data bits MSB first plus even parity,
// serial clock, data and active-low chip select

module frame_serializer (
  input  logic     clk_i,
  input  logic     rst_ni,
  fifo_if.consumer fif,
  output logic     sclk_o,
  output logic     sdo_o,
  output logic     cs_no
);
  import txbuf_pkg::*;

  logic [2:0]            state_q;
  logic [2:0]            state_d;
  logic [FRAME_BITS-1:0] shift_q;
  logic [CNT_W-1:0]      bit_cnt_q;
  logic [DIV_W-1:0]      div_q;
  logic                  bit_end;
  logic                  last_bit;

  // last clk cycle of a bit period
  assign bit_end  = (div_q == DIV_W'(2 * SCLK_HALF - 1));
  assign last_bit = (bit_cnt_q == CNT_W'(FRAME_BITS - 1));

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      FS_IDLE: begin
        if (!fif.empty) begin
          state_d = FS_FETCH;
        end
      end
      FS_FETCH: begin
        // a clear can empty the FIFO in between
        state_d = fif.empty ? FS_IDLE : FS_LOAD;
      end
      FS_LOAD: begin
        state_d = FS_SHIFT;
      end
      FS_SHIFT: begin
        if (bit_end && last_bit) begin
          state_d = FS_GAP;
        end
      end
      FS_GAP: begin
        // chip select stays high one full bit time
        if (bit_end) begin
          state_d = FS_IDLE;
        end
      end
      default: begin
        state_d = FS_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= FS_IDLE;
      div_q     <= '0;
      bit_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == FS_SHIFT || state_q == FS_GAP) begin
        div_q <= bit_end ? '0 : div_q + 1'b1;
      end else begin
        div_q <= '0;
      end
      if (state_q == FS_LOAD) begin
        bit_cnt_q <= '0;
      end else if (state_q == FS_SHIFT && bit_end) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // shift register
  ////////////////////////////////////////////////////////////

  // parity bit makes the count of ones even
  always_ff @(posedge clk_i) begin
    if (state_q == FS_LOAD) begin
      shift_q <= {fif.pop_data, ^fif.pop_data};
    end else if (state_q == FS_SHIFT && bit_end) begin
      shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};
    end
  end

  // pop_data is valid in the LOAD cycle
  assign fif.pop = (state_q == FS_FETCH) & ~fif.empty;

  // sclk low in the first half of a bit, high in the second
  assign cs_no  = (state_q != FS_SHIFT);
  assign sdo_o  = (state_q == FS_SHIFT) & shift_q[FRAME_BITS-1];
  assign sclk_o = (state_q == FS_SHIFT) & (div_q >= DIV_W'(SCLK_HALF));

endmodule

/* source/host_write_port.sv */
// four-phase req/ack slave on the host side
// pushes one byte into the FIFO per request

module host_write_port (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req_i,
  input  logic [txbuf_pkg::DATA_W-1:0] data_i,
  output logic                         ack_o,
  fifo_if.producer                     fif
);
  import txbuf_pkg::*;

  logic [1:0]        state_q;
  logic [1:0]        state_d;
  logic              req_q;
  logic [DATA_W-1:0] data_q;

  // request and data registered together
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q   <= 1'b0;
      state_q <= HW_IDLE;
    end else begin
      req_q   <= req_i;
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    data_q <= data_i;
  end

  ////////////////////////////////////////////////////////////
  // handshake FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d  = state_q;
    fif.push = 1'b0;
    case (state_q)
      HW_IDLE: begin
        // waits here while the FIFO is full
        if (req_q && fif.push_ready) begin
          fif.push = 1'b1;
          state_d  = HW_PUSHED;
        end
      end
      HW_PUSHED: begin
        state_d = req_q ? HW_WAIT : HW_IDLE;
      end
      HW_WAIT: begin
        if (!req_q) begin
          state_d = HW_IDLE;
        end
      end
      default: begin
        state_d = HW_IDLE;
      end
    endcase
  end

  assign fif.push_data = data_q;
  // ack spans from the cycle after the push to the release
  assign ack_o = (state_q != HW_IDLE);

endmodule

/* source/serial_tx_top.sv */
// serial transmit top level
// host write port, byte FIFO and frame serializer

module serial_tx_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clr_i,
  input  logic                          req_i,
  input  logic [txbuf_pkg::DATA_W-1:0]  data_i,
  output logic                          ack_o,
  output logic                          sclk_o,
  output logic                          sdo_o,
  output logic                          cs_no,
  output logic [txbuf_pkg::LEVEL_W-1:0] level_o
);

  // push and pop channels of the FIFO
  fifo_if i_fifo_if (
    .clk_i  (clk_i),
    .rst_ni (rst_ni)
  );

  // host side producer
  host_write_port i_host_write_port (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (req_i),
    .data_i (data_i),
    .ack_o  (ack_o),
    .fif    (i_fifo_if.producer)
  );

  byte_fifo i_byte_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clr_i   (clr_i),
    .fif     (i_fifo_if.buffer),
    .level_o (level_o)
  );

  // serial side consumer
  frame_serializer i_frame_serializer (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .fif    (i_fifo_if.consumer),
    .sclk_o (sclk_o),
    .sdo_o  (sdo_o),
    .cs_no  (cs_no)
  );

endmodule

/* source/sram_sp.sv */
// single-port byte memory with registered read data
// storage behind the byte FIFO

module sram_sp (
  input  logic                          clk_i,
  input  logic                          en_i,
  input  logic                          we_i,
  input  logic [txbuf_pkg::ADDR_W-1:0]  addr_i,
  input  logic [txbuf_pkg::DATA_W-1:0]  wdata_i,
  output logic [txbuf_pkg::DATA_W-1:0]  rdata_o
);
  import txbuf_pkg::*;

  logic [DATA_W-1:0] mem [FIFO_DEPTH];

  // one write or one read per cycle
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        // read data holds until the next read
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

/* source/txbuf_pkg.sv */
// shared constants for the serial transmit buffer
// widths, FIFO depth, serial bit timing and FSM state codes

package txbuf_pkg;

  // data path and storage
  localparam int unsigned DATA_W     = 8;
  localparam int unsigned FIFO_DEPTH = 32;
  localparam int unsigned ADDR_W     = 5;
  // one extra bit so a full FIFO can be counted
  localparam int unsigned LEVEL_W    = 6;

  // serial timing
  localparam int unsigned SCLK_HALF  = 2;
  localparam int unsigned FRAME_BITS = 9;
  localparam int unsigned DIV_W      = $clog2(2 * SCLK_HALF);
  localparam int unsigned CNT_W      = $clog2(FRAME_BITS);

  // host write port states
  localparam logic [1:0] HW_IDLE   = 2'd0;
  localparam logic [1:0] HW_PUSHED = 2'd1;
  localparam logic [1:0] HW_WAIT   = 2'd2;

  // frame serializer states
  localparam logic [2:0] FS_IDLE   = 3'd0;
  localparam logic [2:0] FS_FETCH  = 3'd1;
  localparam logic [2:0] FS_LOAD   = 3'd2;
  localparam logic [2:0] FS_SHIFT  = 3'd3;
  localparam logic [2:0] FS_GAP    = 3'd4;

endpackage

/* verification/tb_util.svh */
// testbench helpers
// LFSR step, reference frame of a byte, value check

`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// 16-bit Fibonacci LFSR with taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  logic fb;
  fb = s[15] ^ s[13] ^ s[12] ^ s[10];
  return {s[14:0], fb};
endfunction

// data bits MSB first, then the parity bit
function automatic logic [FRAME_BITS-1:0] expected_frame(input logic [DATA_W-1:0] b);
  int   ones;
  logic par;
  ones = 0;
  for (int i = 0; i < DATA_W; i++) begin
    ones += int'(b[i]);
  end
  // an odd count of ones needs one more to become even
  par = (ones % 2) != 0;
  return {b, par};
endfunction

// counts each compare and reports a mismatch on one line
task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("error: %s is %h, expected %h", name, got, exp);
  end
endtask

`endif

/* verification/tb_serial_tx.sv */
// testbench for the serial transmit path
// clock, reset, host driver, serial monitor, tests and watchdog

module tb_serial_tx;
  import txbuf_pkg::*;

  localparam int unsigned TOTAL_BYTES     = 1 + 40 + 48 + 6 + 3 + 8;
  localparam int unsigned WATCHDOG_CYCLES =
    TOTAL_BYTES * (FRAME_BITS + 1) * 2 * SCLK_HALF * 4 + 2000;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  clr_i;
  logic                  req_i;
  logic                  ack_o;
  logic                  sclk_o;
  logic                  sdo_o;
  logic                  cs_no;
  logic [DATA_W-1:0]     data_i;
  logic [LEVEL_W-1:0]    level_o;
  logic [LEVEL_W-1:0]    level_prev = '0;
  logic [DATA_W-1:0]     exp_q[$];
  logic [DATA_W-1:0]     cur_byte = '0;
  logic [FRAME_BITS-1:0] cap = '0;
  logic [15:0]           lfsr_q = 16'd20533;
  logic                  in_frame = 1'b0;
  logic                  cs_prev = 1'b1;
  logic                  sclk_prev = 1'b0;
  logic                  ack_prev = 1'b0;
  logic                  full_seen = 1'b0;
  int unsigned           n_bits = 0;
  int unsigned           n_frames = 0;
  int unsigned           n_checks = 0;
  int unsigned           n_errors = 0;
  int unsigned           n_tests = 0;
  int unsigned           gap_cnt = 2 * SCLK_HALF;
  int unsigned           test_err0 = 0;
  int unsigned           test_frames0 = 0;

  `include "tb_util.svh"

  serial_tx_top i_dut (
    .clk_i(clk_i), .rst_ni(rst_ni), .clr_i(clr_i), .req_i(req_i), .data_i(data_i),
    .ack_o(ack_o), .sclk_o(sclk_o), .sdo_o(sdo_o), .cs_no(cs_no), .level_o(level_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // host driver
  ////////////////////////////////////////////////////////////

  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[6:0], lfsr_q[0]};
    end
  endtask

  // one four-phase cycle starting on a rising edge
  task automatic send_byte(input logic [DATA_W-1:0] b);
    req_i  <= 1'b1;
    data_i <= b;
    @(posedge clk_i);
    while (!ack_o) @(posedge clk_i);
    exp_q.push_back(b);
    req_i <= 1'b0;
    @(posedge clk_i);
    while (ack_o) @(posedge clk_i);
  endtask

  task automatic wait_drain();
    @(posedge clk_i);
    while (exp_q.size() != 0 || in_frame || !cs_no) @(posedge clk_i);
  endtask

  task automatic begin_test();
    test_err0    = n_errors;
    test_frames0 = n_frames;
  endtask

  task automatic report_test(input string name);
    n_tests++;
    $display("test %0d %s: %0d frames, %0d errors", n_tests, name,
             n_frames - test_frames0, n_errors - test_err0);
  endtask

  ////////////////////////////////////////////////////////////
  // serial monitor and handshake watch
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (cs_prev && !cs_no) begin
        if (gap_cnt < 2 * SCLK_HALF) begin
          n_errors++;
          $display("chip select was high for only %0d cycles between frames", gap_cnt);
        end
        if (exp_q.size() == 0) begin
          n_errors++;
          $display("a frame started with no byte pending");
        end else begin
          cur_byte = exp_q.pop_front();
        end
        in_frame = 1'b1;
        n_bits   = 0;
      end
      // receiver samples on the rising serial clock
      if (!cs_no && sclk_o && !sclk_prev) begin
        if (!in_frame) begin
          n_errors++;
          $display("a serial bit arrived after the frame was complete");
        end else begin
          cap = {cap[FRAME_BITS-2:0], sdo_o};
          n_bits++;
          if (n_bits == FRAME_BITS) begin
            check("sdo_o frame", cap, expected_frame(cur_byte));
            n_frames++;
            in_frame = 1'b0;
          end
        end
      end
      if (!cs_prev && cs_no && in_frame) begin
        n_errors++;
        $display("a frame ended after only %0d bits", n_bits);
        in_frame = 1'b0;
      end
      gap_cnt = cs_no ? gap_cnt + 1 : 0;
      if (level_o == LEVEL_W'(FIFO_DEPTH)) full_seen = 1'b1;
      if (level_o > LEVEL_W'(FIFO_DEPTH)) check("level_o", level_o, FIFO_DEPTH);
      if (ack_o && !ack_prev && !req_i) begin
        n_errors++;
        $display("ack_o rose while req_i was low");
      end
      if (ack_o && !ack_prev && level_prev == LEVEL_W'(FIFO_DEPTH)) begin
        n_errors++;
        $display("ack_o rose while the FIFO was full");
      end
      if (!ack_o && ack_prev && req_i) begin
        n_errors++;
        $display("ack_o fell before req_i was released");
      end
    end
    cs_prev    = cs_no;
    sclk_prev  = sclk_o;
    ack_prev   = ack_o;
    level_prev = level_o;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  initial begin
    logic [DATA_W-1:0] b;
    logic [7:0]        gap;
    int unsigned       clr_frames;
    rst_ni = 1'b0;
    clr_i  = 1'b0;
    req_i  = 1'b0;
    data_i = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (2) @(posedge clk_i);

    begin_test();
    check("ack_o", ack_o, 0);
    check("sclk_o", sclk_o, 0);
    check("sdo_o", sdo_o, 0);
    check("cs_no", cs_no, 1);
    check("level_o", level_o, 0);
    report_test("reset state");

    begin_test();
    take_bits(8, b);
    send_byte(b);
    wait_drain();
    check("frame count", n_frames - test_frames0, 1);
    report_test("single byte");

    begin_test();
    repeat (40) begin
      take_bits(8, b);
      send_byte(b);
    end
    wait_drain();
    check("frame count", n_frames - test_frames0, 40);
    report_test("random burst");

    begin_test();
    full_seen = 1'b0;
    repeat (48) begin
      take_bits(8, b);
      send_byte(b);
    end
    wait_drain();
    check("full level seen", full_seen, 1);
    check("frame count", n_frames - test_frames0, 48);
    report_test("back-pressure");

    begin_test();
    repeat (6) begin
      take_bits(8, b);
      send_byte(b);
    end
    // clear just after a fresh frame has started
    while (!cs_no) @(posedge clk_i);
    while (cs_no) @(posedge clk_i);
    @(posedge clk_i);
    if (level_o == 0) begin
      n_errors++;
      $display("the FIFO was already empty before the clear");
    end
    clr_frames = n_frames;
    clr_i <= 1'b1;
    exp_q.delete();
    @(posedge clk_i);
    clr_i <= 1'b0;
    @(posedge clk_i);
    check("level_o", level_o, 0);
    repeat (3) begin
      take_bits(8, b);
      send_byte(b);
    end
    wait_drain();
    check("frames after clear", n_frames - clr_frames, 4);
    report_test("clear");

    begin_test();
    repeat (8) begin
      take_bits(3, gap);
      repeat (gap) @(posedge clk_i);
      take_bits(8, b);
      send_byte(b);
    end
    wait_drain();
    check("frame count", n_frames - test_frames0, 8);
    report_test("handshake order");

    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
